// File: ScalarShifterPkg.sv
package ScalarShifterPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths and address map

	localparam int LineWidth = 256; // bits per data line.
	localparam int ScalarWidth = 64; // scalar bus, also the widest element.
	localparam int NumLines = 4;
	localparam int LineIndexWidth = 2;
	localparam int DataOffsetWidth = 5; // byte offset within a line.
	localparam int AdrWidth = 8;

	localparam int ScalarWindowBit = 7; // set for scalar access, clear for metadata.
	localparam int LineIndexLsb = 5; // line index sits in adr[6:5] of the scalar window.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// encodings

	typedef enum logic [1:0]
	{
		DataTypUnsgnInt,
		DataTypSgnInt,
		DataTypBFloat16,
		DataTypReserved
	} DataType;

	typedef enum logic [1:0]
	{
		IntTypSz8,
		IntTypSz16,
		IntTypSz32,
		IntTypSz64
	} IntTypeSize;

	typedef struct packed
	{
		DataType dataType;
		IntTypeSize intTypeSize;
	} LineMeta;

	localparam LineMeta MetaResetValue = '{dataType: DataTypUnsgnInt, intTypeSize: IntTypSz8};

	typedef struct packed
	{
		logic [LineWidth-1:0] toShift;
		DataType dataType;
		IntTypeSize intTypeSize;
		logic [DataOffsetWidth-1:0] dataOffset;
	} ShifterReadIn;

	typedef struct packed
	{
		logic [LineWidth-1:0] toModify;
		logic [ScalarWidth-1:0] toShift;
		DataType dataType;
		IntTypeSize intTypeSize;
		logic [DataOffsetWidth-1:0] dataOffset;
	} ShifterWriteIn;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Wishbone classic

	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		logic [AdrWidth-1:0] adr;
		logic [ScalarWidth-1:0] dat;
	} WbReq;

	typedef struct packed
	{
		logic ack;
		logic [ScalarWidth-1:0] dat;
	} WbRsp;

	// bfloat16 elements occupy the same slots as 16-bit integers.
	function automatic IntTypeSize EffectiveSize(input DataType dataType,
		input IntTypeSize intTypeSize);
		return (dataType == DataTypBFloat16) ? IntTypSz16 : intTypeSize;
	endfunction

endpackage

// File: ScalarDataShifterForRead.sv
`timescale 1ns/1ns

// Extraction only, there is no casting and no sign extension.
module ScalarDataShifterForRead import ScalarShifterPkg::*;
(
	input ShifterReadIn in,
	output logic [ScalarWidth-1:0] out
);

	IntTypeSize elemSize;

	assign elemSize = EffectiveSize(in.dataType, in.intTypeSize);

	always_comb
	begin
		out = '0; // upper bits stay zero for narrow elements.
		if (in.dataType != DataTypReserved)
		begin
			case (elemSize)
			IntTypSz8:
			begin
				out[7:0] = in.toShift[in.dataOffset * 8 +: 8];
			end
			IntTypSz16:
			begin
				// dropping the low offset bits rounds down to the element.
				out[15:0] = in.toShift[in.dataOffset[4:1] * 16 +: 16];
			end
			IntTypSz32:
			begin
				out[31:0] = in.toShift[in.dataOffset[4:2] * 32 +: 32];
			end
			default:
			begin
				out = in.toShift[in.dataOffset[4:3] * 64 +: 64];
			end
			endcase
		end
	end

endmodule

// File: ScalarDataShifterForWrite.sv
`timescale 1ns/1ns

module ScalarDataShifterForWrite import ScalarShifterPkg::*;
(
	input ShifterWriteIn in,
	output logic [LineWidth-1:0] out
);

	IntTypeSize elemSize;

	assign elemSize = EffectiveSize(in.dataType, in.intTypeSize);

	always_comb
	begin
		out = in.toModify; // every byte outside the element is kept.
		if (in.dataType == DataTypReserved)
		begin
			out = '0; // a reserved write wipes the line.
		end
		else
		begin
			case (elemSize)
			IntTypSz8:
			begin
				out[in.dataOffset * 8 +: 8] = in.toShift[7:0];
			end
			IntTypSz16:
			begin
				out[in.dataOffset[4:1] * 16 +: 16] = in.toShift[15:0];
			end
			IntTypSz32:
			begin
				out[in.dataOffset[4:2] * 32 +: 32] = in.toShift[31:0];
			end
			default:
			begin
				out[in.dataOffset[4:3] * 64 +: 64] = in.toShift;
			end
			endcase
		end
	end

endmodule

// File: LineStore.sv
`timescale 1ns/1ns

module LineStore import ScalarShifterPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic [LineIndexWidth-1:0] rdIndex,
	input logic wrEn,
	input logic [LineIndexWidth-1:0] wrIndex,
	input logic [LineWidth-1:0] wrLine,
	output logic [LineWidth-1:0] rdLine
);

	logic [LineWidth-1:0] lines [NumLines];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < NumLines; i++)
			begin
				lines[i] <= '0;
			end
			rdLine <= '0;
		end
		else
		begin
			rdLine <= lines[rdIndex]; // same-index write shows up next cycle.
			if (wrEn)
			begin
				lines[wrIndex] <= wrLine;
			end
		end
	end

endmodule

// File: LineMetadataRegs.sv
`timescale 1ns/1ns

// Per-line type and size, steering every scalar access to that line.
module LineMetadataRegs import ScalarShifterPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic metaWe,
	input logic [LineIndexWidth-1:0] metaWrIndex,
	input LineMeta metaWrData,
	input logic [LineIndexWidth-1:0] lookupIndex,
	output LineMeta lookupMeta
);

	LineMeta [NumLines-1:0] entries;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < NumLines; i++)
			begin
				entries[i] <= MetaResetValue; // unsigned 8-bit.
			end
		end
		else if (metaWe)
		begin
			entries[metaWrIndex] <= metaWrData;
		end
	end

	assign lookupMeta = entries[lookupIndex]; // no latency.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks

	// A bus write with undriven data would poison later shifts.
	metaKnown: assert property (@(posedge clk) disable iff (!rstN)
		!$isunknown(entries));

endmodule

// File: ScalarAccessCtrl.sv
`timescale 1ns/1ns

module ScalarAccessCtrl import ScalarShifterPkg::*;
(
	input logic clk,
	input logic rstN,
	input WbReq wbIn,
	input logic [LineWidth-1:0] rdLine,
	input LineMeta lookupMeta,
	input logic [ScalarWidth-1:0] readData,
	input logic [LineWidth-1:0] writeLine,
	output WbRsp wbOut,
	output logic [LineIndexWidth-1:0] rdIndex,
	output logic wrEn,
	output logic [LineIndexWidth-1:0] wrIndex,
	output logic [LineWidth-1:0] wrLine,
	output logic metaWe,
	output logic [LineIndexWidth-1:0] metaWrIndex,
	output LineMeta metaWrData,
	output logic [LineIndexWidth-1:0] lookupIndex,
	output ShifterReadIn readIn,
	output ShifterWriteIn writeIn
);

	typedef enum logic [1:0] {StIdle, StCapture, StRespond} State;

	State state;
	logic reqWe;
	logic [LineIndexWidth-1:0] reqLine;
	logic [DataOffsetWidth-1:0] reqOffset;
	logic [ScalarWidth-1:0] reqDat;
	logic [ScalarWidth-1:0] rspDat;
	logic newReq;
	logic newScalar;

	assign newReq = (state == StIdle) && wbIn.cyc && wbIn.stb;
	assign newScalar = wbIn.adr[ScalarWindowBit];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencing

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= StIdle;
			reqWe <= 1'b0;
		end
		else
		begin
			case (state)
			StIdle:
			begin
				if (newReq)
				begin
					state <= newScalar ? StCapture : StRespond; // metadata answers at once.
					reqWe <= wbIn.we;
				end
			end
			StCapture:
			begin
				state <= StRespond;
			end
			default:
			begin
				state <= StIdle; // one idle cycle keeps a held stb from retriggering.
			end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (newReq)
		begin
			reqLine <= wbIn.adr[LineIndexLsb +: LineIndexWidth];
			reqOffset <= wbIn.adr[DataOffsetWidth-1:0];
			reqDat <= wbIn.dat;
		end
		if (newReq && !newScalar)
		begin
			rspDat <= ScalarWidth'(lookupMeta);
		end
		else if (state == StCapture)
		begin
			rspDat <= readData;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// block controls

	assign rdIndex = wbIn.adr[LineIndexLsb +: LineIndexWidth]; // line lands in rdLine at edge 1.
	assign wrEn = (state == StCapture) && reqWe;
	assign wrIndex = reqLine;
	assign wrLine = writeLine;

	assign metaWe = newReq && !newScalar && wbIn.we;
	assign metaWrIndex = wbIn.adr[LineIndexWidth-1:0];
	assign metaWrData = LineMeta'(wbIn.dat[$bits(LineMeta)-1:0]);
	assign lookupIndex = (state == StIdle) ? metaWrIndex : reqLine;

	assign readIn = '{toShift: rdLine, dataType: lookupMeta.dataType,
		intTypeSize: lookupMeta.intTypeSize, dataOffset: reqOffset};
	assign writeIn = '{toModify: rdLine, toShift: reqDat, dataType: lookupMeta.dataType,
		intTypeSize: lookupMeta.intTypeSize, dataOffset: reqOffset};

	assign wbOut.ack = (state == StRespond);
	assign wbOut.dat = rspDat;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks

	ackSingle: assert property (@(posedge clk) disable iff (!rstN)
		wbOut.ack |=> !wbOut.ack);

	ackInCycle: assert property (@(posedge clk) disable iff (!rstN)
		wbOut.ack |-> wbIn.cyc && wbIn.stb);

	// The write-back belongs to the cycle that produces a scalar write's ack.
	wrOnlyScalarWrite: assert property (@(posedge clk) disable iff (!rstN)
		wrEn |=> wbOut.ack && wbIn.we && wbIn.adr[ScalarWindowBit]);

endmodule

// File: ScalarAccessTop.sv
`timescale 1ns/1ns

module ScalarAccessTop import ScalarShifterPkg::*;
(
	input logic clk,
	input logic rstN,
	input WbReq wbIn,
	output WbRsp wbOut
);

	logic [LineIndexWidth-1:0] rdIndex;
	logic wrEn;
	logic [LineIndexWidth-1:0] wrIndex;
	logic [LineWidth-1:0] wrLine;
	logic [LineWidth-1:0] rdLine;
	logic metaWe;
	logic [LineIndexWidth-1:0] metaWrIndex;
	LineMeta metaWrData;
	logic [LineIndexWidth-1:0] lookupIndex;
	LineMeta lookupMeta;
	ShifterReadIn readIn;
	ShifterWriteIn writeIn;
	logic [ScalarWidth-1:0] readData;
	logic [LineWidth-1:0] writeLine;

	ScalarAccessCtrl ctrl
	(
		.clk(clk),
		.rstN(rstN),
		.wbIn(wbIn),
		.rdLine(rdLine),
		.lookupMeta(lookupMeta),
		.readData(readData),
		.writeLine(writeLine),
		.wbOut(wbOut),
		.rdIndex(rdIndex),
		.wrEn(wrEn),
		.wrIndex(wrIndex),
		.wrLine(wrLine),
		.metaWe(metaWe),
		.metaWrIndex(metaWrIndex),
		.metaWrData(metaWrData),
		.lookupIndex(lookupIndex),
		.readIn(readIn),
		.writeIn(writeIn)
	);

	LineStore lineStore
	(
		.clk(clk),
		.rstN(rstN),
		.rdIndex(rdIndex),
		.wrEn(wrEn),
		.wrIndex(wrIndex),
		.wrLine(wrLine),
		.rdLine(rdLine)
	);

	LineMetadataRegs metaRegs
	(
		.clk(clk),
		.rstN(rstN),
		.metaWe(metaWe),
		.metaWrIndex(metaWrIndex),
		.metaWrData(metaWrData),
		.lookupIndex(lookupIndex),
		.lookupMeta(lookupMeta)
	);

	ScalarDataShifterForRead readShifter
	(
		.in(readIn),
		.out(readData)
	);

	ScalarDataShifterForWrite writeShifter
	(
		.in(writeIn),
		.out(writeLine)
	);

endmodule

// File: ScalarAccessTb.sv
`timescale 1ns/1ns

module ScalarAccessTb import ScalarShifterPkg::*;
();

	localparam int ResetCycles = 8;
	localparam int CyclesPerOp = 6; // budget per stimulus line for the run limit.
	localparam int AckLimit = 5;
	localparam int MaxOps = 64;
	localparam logic [63:0] EndMark = '1; // marks words the stimulus file did not fill.

	logic clk;
	logic rstN;
	WbReq wbIn;
	WbRsp wbOut;

	logic [63:0] stimWords [4*MaxOps]; // four words per operation.
	int numOps;
	int errorCount;
	int checkCount;
	int cycleCount;
	bit stimLoaded;

	ScalarAccessTop UUT
	(
		.clk(clk),
		.rstN(rstN),
		.wbIn(wbIn),
		.wbOut(wbOut)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2 clk = ~clk;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// run limit

	initial
	begin
		cycleCount = 0;
		wait (stimLoaded);
		while (cycleCount < numOps * CyclesPerOp + ResetCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Run stopped after %0d cycles without reaching the end of the stimulus.",
			cycleCount);
		$display("TESTS FAILED");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// one Wishbone classic transfer

	// Called just after a falling edge; returns just after a falling edge.
	task automatic busTransfer(input logic [1:0] op, input logic [AdrWidth-1:0] adr,
		input logic [63:0] wrData, input logic [63:0] expData);
		int latency;
		int wantLatency;
		logic isRead;
		latency = 0;
		wantLatency = adr[ScalarWindowBit] ? 2 : 1; // scalar accesses read the line first.
		isRead = op[0];
		wbIn.cyc = 1'b1;
		wbIn.stb = 1'b1;
		wbIn.we = !isRead;
		wbIn.adr = adr;
		wbIn.dat = wrData;
		do
		begin
			@(negedge clk);
			latency++;
		end
		while (!wbOut.ack && latency < AckLimit);
		checkCount++;
		assert (wbOut.ack)
		else
		begin
			errorCount++;
			$display("No ack within %0d cycles for address %h at time %0t.", AckLimit, adr,
				$time);
		end
		if (wbOut.ack)
		begin
			checkCount++;
			assert (latency == wantLatency)
			else
			begin
				errorCount++;
				$display("Fail time=%0t signal=ackLatency expected=%0d actual=%0d", $time,
					wantLatency, latency);
			end
			if (isRead)
			begin
				checkCount++;
				assert (wbOut.dat == expData)
				else
				begin
					errorCount++;
					$display("Fail time=%0t signal=wbOut.dat expected=%h actual=%h", $time,
						expData, wbOut.dat);
				end
			end
			@(posedge clk); // the slave sees stb still high while ack is up.
			@(negedge clk);
			checkCount++;
			assert (!wbOut.ack)
			else
			begin
				errorCount++;
				$display("Fail time=%0t signal=wbOut.ack expected=0 actual=%b", $time,
					wbOut.ack);
			end
		end
		wbIn.cyc = 1'b0;
		wbIn.stb = 1'b0;
		wbIn.we = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence

	initial
	begin
		rstN = 1'b0;
		wbIn = '0;
		errorCount = 0;
		checkCount = 0;
		numOps = 0;
		for (int i = 0; i < 4 * MaxOps; i++)
		begin
			stimWords[i] = EndMark;
		end
		$readmemh("scalarStim.txt", stimWords);
		while (numOps < MaxOps && stimWords[4 * numOps] != EndMark)
		begin
			numOps++;
		end
		if (numOps == 0)
		begin
			errorCount++;
			$display("No operations could be read from scalarStim.txt.");
		end
		stimLoaded = 1'b1;

		repeat (ResetCycles) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);

		for (int i = 0; i < numOps; i++)
		begin
			busTransfer(stimWords[4 * i][1:0], stimWords[4 * i + 1][AdrWidth-1:0],
				stimWords[4 * i + 2], stimWords[4 * i + 3]);
		end

		$display("Operations: %0d, checks: %0d, errors: %0d", numOps, checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: scalarStim.txt
// op adr wdata expected, all hex; expected is checked on reads only.
// op: 0 metadata write, 1 metadata read, 2 scalar write, 3 scalar read.
1 00 0 0
1 03 0 0
3 80 0 0
3 FF 0 0
0 01 1 0
1 01 0 1
2 A4 1122334455667788 0
3 A4 0 7788
0 02 2 0
2 C8 CAFEBABEDEADBEEF 0
3 C8 0 DEADBEEF
0 03 3 0
2 F0 0123456789ABCDEF 0
3 F0 0 0123456789ABCDEF
2 85 A5A5A5A5A5A5A55A 0
3 85 0 5A
3 84 0 0
3 CB 0 DEADBEEF
3 F5 0 0123456789ABCDEF
2 A7 9999 0
3 A6 0 9999
3 A4 0 7788
3 C4 0 0
0 01 0 0
3 A5 0 77
3 A7 0 99
0 02 8 0
1 02 0 8
3 CA 0 DEAD
2 CB 1234 0
3 C9 0 BEEF
3 CA 0 1234
0 03 F 0
1 03 0 F
3 F0 0 0
2 E0 55 0
0 03 0 0
3 F0 0 0
3 F7 0 0

// File: files.f
ScalarShifterPkg.sv
ScalarDataShifterForRead.sv
ScalarDataShifterForWrite.sv
LineStore.sv
LineMetadataRegs.sv
ScalarAccessCtrl.sv
ScalarAccessTop.sv
ScalarAccessTb.sv
